/* all.f */
+incdir+hw
hw/wbuf_pkg.sv
hw/wbuf_store.sv
hw/wbuf_issue.sv
hw/wbuf_retire.sv
hw/wbuf_top.sv
bench/wbuf_asserts.sv
bench/wbuf_tb.sv

/* bench/wbuf_tb.sv */
// testbench of the coalescing write buffer
// random stores into 8 dwords, a memory model that acks at random and answers
// out of order, and a shadow copy of every granted byte that is compared with
// the memory image once the buffer has drained

`timescale 1ns/1ps
`default_nettype none

`include "wbuf_params.svh"

module wbuf_tb;

  localparam int TAG_W = `WBUF_ADDR_W - $clog2(`WBUF_BE_W);
  localparam int ID_W  = $clog2(`WBUF_MAX_TX);
  localparam int N_DW  = 8;
  localparam int N_MIX = 40;
  // about 80 cycles per store covers stalls, full buffer and late responses
  localparam int MAX_CYCLES = 80 * (N_MIX + 10);
  localparam logic [31:0] BASE = 32'h0000_2000;

  logic                    clk_i = 1'b0;
  logic                    reset_i = 1'b1;
  logic                    st_req_i = 1'b0;
  logic [31:0]             st_addr_i = '0;
  logic [63:0]             st_data_i = '0;
  logic [7:0]              st_be_i = '0;
  logic                    st_gnt_o;
  logic                    mem_req_o;
  logic [TAG_W-1:0]        mem_wtag_o;
  logic [63:0]             mem_data_o;
  logic [7:0]              mem_be_o;
  logic [ID_W-1:0]         mem_id_o;
  logic                    mem_ack_i = 1'b0;
  logic                    mem_rtrn_vld_i = 1'b0;
  logic [ID_W-1:0]         mem_rtrn_id_i = '0;
  logic                    empty_o;

  // byte images of the 8 dwords behind BASE
  logic [7:0] mem_img [N_DW*8];
  logic [7:0] shadow [N_DW*8];

  // transactions the memory has taken and not answered
  logic [ID_W-1:0]  out_id [$];
  logic [TAG_W-1:0] out_wtag [$];
  logic [63:0]      out_data [$];
  logic [7:0]       out_be [$];

  int   err_cnt = 0;
  int   cycle_cnt = 0;
  logic hold_ack = 1'b1;
  int   perm [N_DW];

  wbuf_top dut_i (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("summary: %0d check errors, %0d assertion failures, 1 timeout",
               err_cnt, dut_i.asserts_i.fail_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory model, drives on the falling edge, samples 10 ns later
  ////////////////////////////////////////////////////////////////////////////

  always begin : mem_model
    int i;
    @(negedge clk_i);
    mem_ack_i      = hold_ack ? 1'b0 : ($urandom % 2 == 0);
    mem_rtrn_vld_i = 1'b0;
    // answer a random outstanding write, bytes land in memory now
    if (out_id.size() > 0 && $urandom % 3 == 0) begin
      i = $urandom % out_id.size();
      mem_rtrn_vld_i = 1'b1;
      mem_rtrn_id_i  = out_id[i];
      for (int b = 0; b < 8; b++) begin
        if (out_be[i][b]) begin
          mem_img[int'(out_wtag[i][2:0]) * 8 + b] = out_data[i][b*8 +: 8];
        end
      end
      out_id.delete(i);
      out_wtag.delete(i);
      out_data.delete(i);
      out_be.delete(i);
    end
    #10;
    if (mem_req_o && mem_ack_i) begin
      check_value("mem_wtag_o", 64'(mem_wtag_o[TAG_W-1:3]), 64'(BASE >> 6));
      out_id.push_back(mem_id_o);
      out_wtag.push_back(mem_wtag_o);
      out_data.push_back(mem_data_o);
      out_be.push_back(mem_be_o);
    end
  end

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("[ERROR] %s = %h, expected %h", name, got, exp);
    end
  endtask

  // store one dword from a falling edge on, returns on the edge after its grant
  task automatic store_dword(input int idx, input logic expect_gnt);
    logic [63:0] data;
    logic [7:0]  be;
    data = {$urandom, $urandom};
    be   = 8'($urandom);
    if (be == 8'h00) begin
      be = 8'h01;
    end
    st_req_i  = 1'b1;
    st_addr_i = BASE + 32'(idx * 8) + 32'($urandom % 8);
    st_data_i = data;
    st_be_i   = be;
    #10;
    if (expect_gnt) begin
      check_value("st_gnt_o", 64'(st_gnt_o), 64'(1));
    end
    while (!st_gnt_o) begin
      @(negedge clk_i);
      #10;
    end
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        shadow[idx*8 + b] = data[b*8 +: 8];
      end
    end
    @(negedge clk_i);
    st_req_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int j;
    int tmp;
    void'($urandom(32'h75d18184));
    for (int a = 0; a < N_DW*8; a++) begin
      mem_img[a] = 8'(a * 29 + 8'h3b);
      shadow[a]  = mem_img[a];
    end
    // random order of the dword indices, the first four fill the buffer
    for (int k = 0; k < N_DW; k++) begin
      perm[k] = k;
    end
    for (int k = N_DW-1; k > 0; k--) begin
      j       = $urandom % (k + 1);
      tmp     = perm[k];
      perm[k] = perm[j];
      perm[j] = tmp;
    end

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    #10;
    check_value("empty_o", 64'(empty_o), 64'(1));
    check_value("mem_req_o", 64'(mem_req_o), 64'(0));
    check_value("st_gnt_o", 64'(st_gnt_o), 64'(1));
    @(negedge clk_i);

    // burst into all entries while the memory stalls
    for (int k = 0; k < 4; k++) begin
      store_dword(perm[k], 1'b1);
    end
    st_req_i  = 1'b1;
    st_addr_i = BASE + 32'(perm[4] * 8);
    st_data_i = {$urandom, $urandom};
    st_be_i   = 8'hff;
    repeat (3) begin
      #10;
      check_value("st_gnt_o", 64'(st_gnt_o), 64'(0));
      @(negedge clk_i);
    end
    st_req_i = 1'b0;
    // a hit still coalesces into the full buffer
    store_dword(perm[$urandom % 4], 1'b1);
    repeat (3) @(negedge clk_i);

    // rewrites of the few dwords while their writes are in flight
    hold_ack = 1'b0;
    for (int n = 0; n < N_MIX; n++) begin
      store_dword($urandom % N_DW, 1'b0);
      repeat ($urandom % 3) @(negedge clk_i);
    end

    // drain, nothing is pushed to the memory while empty_o is high
    #10;
    while (!(empty_o && out_id.size() == 0)) begin
      @(negedge clk_i);
      #10;
    end
    for (int a = 0; a < N_DW*8; a++) begin
      assert (mem_img[a] === shadow[a]) else begin
        err_cnt++;
        $display("[ERROR] mem_img byte %h = %h, expected %h", BASE + 32'(a), mem_img[a],
                 shadow[a]);
      end
    end
    repeat (2) @(negedge clk_i);

    $display("summary: %0d check errors, %0d assertion failures, 0 timeouts",
             err_cnt, dut_i.asserts_i.fail_cnt);
    if (err_cnt == 0 && dut_i.asserts_i.fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/wbuf_asserts.sv */
// port-level checks of the write buffer memory interface
// bound into every wbuf_top instance, tracks the outstanding IDs on its own
// from transfers and responses and flags protocol breaks with $error

`timescale 1ns/1ps
`default_nettype none

`include "wbuf_params.svh"

module wbuf_asserts (
  input logic                                            clk_i,
  input logic                                            reset_i,
  input logic                                            mem_req_i,
  input logic [`WBUF_ADDR_W-$clog2(`WBUF_BE_W)-1:0]      mem_wtag_i,
  input logic [`WBUF_DATA_W-1:0]                         mem_data_i,
  input logic [`WBUF_BE_W-1:0]                           mem_be_i,
  input logic [$clog2(`WBUF_MAX_TX)-1:0]                 mem_id_i,
  input logic                                            mem_ack_i,
  input logic                                            mem_rtrn_vld_i,
  input logic [$clog2(`WBUF_MAX_TX)-1:0]                 mem_rtrn_id_i
);

  localparam int TAG_W = `WBUF_ADDR_W - $clog2(`WBUF_BE_W);

  // failed assertions so far
  int unsigned fail_cnt = 0;

  // outstanding transactions seen on the ports
  logic [`WBUF_MAX_TX-1:0] out_q;
  logic [TAG_W-1:0]        out_wtag_q [`WBUF_MAX_TX];
  logic [`WBUF_BE_W-1:0]   out_be_q [`WBUF_MAX_TX];
  int                      out_cnt_q;
  logic                    xfer;
  logic                    overlap;

  assign xfer = mem_req_i & mem_ack_i;

  // new transfer shares bytes with one still in flight to the same dword
  always_comb begin : p_overlap
    overlap = 1'b0;
    for (int t = 0; t < `WBUF_MAX_TX; t++) begin
      if (out_q[t] && (out_wtag_q[t] == mem_wtag_i) && |(out_be_q[t] & mem_be_i)) begin
        overlap = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_track
    if (reset_i) begin
      out_q     <= '0;
      out_cnt_q <= 0;
    end else begin
      if (mem_rtrn_vld_i) begin
        out_q[mem_rtrn_id_i] <= 1'b0;
      end
      if (xfer) begin
        out_q[mem_id_i]      <= 1'b1;
        out_wtag_q[mem_id_i] <= mem_wtag_i;
        out_be_q[mem_id_i]   <= mem_be_i;
      end
      out_cnt_q <= out_cnt_q + int'(xfer) - int'(mem_rtrn_vld_i);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // port rules
  ////////////////////////////////////////////////////////////////////////////

  // stalled request keeps every field
  a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_wtag_i) && $stable(mem_data_i)
      && $stable(mem_be_i) && $stable(mem_id_i))
    else begin
      $error("memory request changed while mem_ack_i was low");
      fail_cnt++;
    end

  a_id_free: assert property (@(posedge clk_i) disable iff (reset_i)
    xfer |-> !out_q[mem_id_i])
    else begin
      $error("transaction ID %0d issued while still outstanding", mem_id_i);
      fail_cnt++;
    end

  a_max_out: assert property (@(posedge clk_i) disable iff (reset_i)
    out_cnt_q <= `WBUF_MAX_TX)
    else begin
      $error("%0d transactions outstanding", out_cnt_q);
      fail_cnt++;
    end

  a_no_overlap: assert property (@(posedge clk_i) disable iff (reset_i)
    xfer |-> !overlap)
    else begin
      $error("byte mask overlaps an in-flight write to the same dword");
      fail_cnt++;
    end

endmodule

bind wbuf_top wbuf_asserts asserts_i (
  .clk_i          ( clk_i          ),
  .reset_i        ( reset_i        ),
  .mem_req_i      ( mem_req_o      ),
  .mem_wtag_i     ( mem_wtag_o     ),
  .mem_data_i     ( mem_data_o     ),
  .mem_be_i       ( mem_be_o       ),
  .mem_id_i       ( mem_id_o       ),
  .mem_ack_i      ( mem_ack_i      ),
  .mem_rtrn_vld_i ( mem_rtrn_vld_i ),
  .mem_rtrn_id_i  ( mem_rtrn_id_i  )
);

`default_nettype wire

/* hw/wbuf_top.sv */
// top level of the coalescing write buffer
// core store port in, split write transactions out, responses back in any
// order; store, issue and retire stages are wired here and nothing else

`timescale 1ns/1ps
`default_nettype none

`include "wbuf_params.svh"

module wbuf_top import wbuf_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // core store port
  input  logic                    st_req_i,
  input  logic [`WBUF_ADDR_W-1:0] st_addr_i,
  input  dword_t                  st_data_i,
  input  be_t                     st_be_i,
  output logic                    st_gnt_o,
  // memory request port
  output logic                    mem_req_o,
  output wtag_t                   mem_wtag_o,
  output dword_t                  mem_data_o,
  output be_t                     mem_be_o,
  output tx_id_t                  mem_id_o,
  input  logic                    mem_ack_i,
  // memory response port
  input  logic                    mem_rtrn_vld_i,
  input  tx_id_t                  mem_rtrn_id_i,
  // status
  output logic                    empty_o
);

  // store to issue
  entry_mask_t              dirty;
  be_t    [`WBUF_DEPTH-1:0] bdirty;
  wtag_t  [`WBUF_DEPTH-1:0] wtag;
  dword_t [`WBUF_DEPTH-1:0] data;
  // issue to store
  logic       sent;
  entry_ptr_t sent_ptr;
  be_t        sent_be;
  // issue to retire
  logic       alloc;
  tx_id_t     alloc_id;
  entry_ptr_t alloc_ptr;
  be_t        alloc_be;
  // retire to issue and store
  tx_mask_t   tx_free;
  logic       evict;
  entry_ptr_t evict_ptr;
  be_t        evict_be;

  wbuf_store store_i (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .st_req_i    ( st_req_i  ),
    .st_addr_i   ( st_addr_i ),
    .st_data_i   ( st_data_i ),
    .st_be_i     ( st_be_i   ),
    .st_gnt_o    ( st_gnt_o  ),
    .sent_i      ( sent      ),
    .sent_ptr_i  ( sent_ptr  ),
    .sent_be_i   ( sent_be   ),
    .evict_i     ( evict     ),
    .evict_ptr_i ( evict_ptr ),
    .evict_be_i  ( evict_be  ),
    .dirty_o     ( dirty     ),
    .bdirty_o    ( bdirty    ),
    .wtag_o      ( wtag      ),
    .data_o      ( data      ),
    .empty_o     ( empty_o   )
  );

  wbuf_issue issue_i (
    .clk_i       ( clk_i      ),
    .reset_i     ( reset_i    ),
    .dirty_i     ( dirty      ),
    .bdirty_i    ( bdirty     ),
    .wtag_i      ( wtag       ),
    .data_i      ( data       ),
    .tx_free_i   ( tx_free    ),
    .mem_req_o   ( mem_req_o  ),
    .mem_wtag_o  ( mem_wtag_o ),
    .mem_data_o  ( mem_data_o ),
    .mem_be_o    ( mem_be_o   ),
    .mem_id_o    ( mem_id_o   ),
    .mem_ack_i   ( mem_ack_i  ),
    .sent_o      ( sent       ),
    .sent_ptr_o  ( sent_ptr   ),
    .sent_be_o   ( sent_be    ),
    .alloc_o     ( alloc      ),
    .alloc_id_o  ( alloc_id   ),
    .alloc_ptr_o ( alloc_ptr  ),
    .alloc_be_o  ( alloc_be   )
  );

  wbuf_retire retire_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .alloc_i        ( alloc          ),
    .alloc_id_i     ( alloc_id       ),
    .alloc_ptr_i    ( alloc_ptr      ),
    .alloc_be_i     ( alloc_be       ),
    .mem_rtrn_vld_i ( mem_rtrn_vld_i ),
    .mem_rtrn_id_i  ( mem_rtrn_id_i  ),
    .tx_free_o      ( tx_free        ),
    .evict_o        ( evict          ),
    .evict_ptr_o    ( evict_ptr      ),
    .evict_be_o     ( evict_be       )
  );

endmodule

`default_nettype wire

/* hw/wbuf_retire.sv */
// retire stage of the write buffer
// keeps one slot per transaction ID with the entry and bytes it carries,
// queues returned IDs in a small FIFO and turns the FIFO head into an
// eviction command for store, one response per cycle

`timescale 1ns/1ps
`default_nettype none

`include "wbuf_params.svh"

module wbuf_retire import wbuf_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  // slot allocation from issue
  input  logic       alloc_i,
  input  tx_id_t     alloc_id_i,
  input  entry_ptr_t alloc_ptr_i,
  input  be_t        alloc_be_i,
  // memory response port
  input  logic       mem_rtrn_vld_i,
  input  tx_id_t     mem_rtrn_id_i,
  // to issue and store
  output tx_mask_t   tx_free_o,
  output logic       evict_o,
  output entry_ptr_t evict_ptr_o,
  output be_t        evict_be_o
);

  // transaction slots
  tx_mask_t                        slot_vld_q;
  entry_ptr_t [`WBUF_MAX_TX-1:0]   slot_ptr_q;
  be_t        [`WBUF_MAX_TX-1:0]   slot_be_q;

  // return-ID fifo, as deep as there are IDs so it never overflows
  tx_id_t [`WBUF_MAX_TX-1:0]       fifo_q;
  tx_id_t                          fifo_wr_q;
  tx_id_t                          fifo_rd_q;
  logic   [$clog2(`WBUF_MAX_TX):0] fifo_cnt_q;
  tx_id_t                          rtrn_id;

  assign rtrn_id     = fifo_q[fifo_rd_q];
  // head popped every cycle it is present
  assign evict_o     = (fifo_cnt_q != '0);
  assign evict_ptr_o = slot_ptr_q[rtrn_id];
  assign evict_be_o  = slot_be_q[rtrn_id];
  assign tx_free_o   = ~slot_vld_q;

  always_ff @(posedge clk_i) begin : p_fifo_ctrl
    if (reset_i) begin
      fifo_wr_q  <= '0;
      fifo_rd_q  <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (mem_rtrn_vld_i) begin
        fifo_wr_q <= fifo_wr_q + tx_id_t'(1);
      end
      if (evict_o) begin
        fifo_rd_q <= fifo_rd_q + tx_id_t'(1);
      end
      case ({mem_rtrn_vld_i, evict_o})
        2'b10:   fifo_cnt_q <= fifo_cnt_q + 1'b1;
        2'b01:   fifo_cnt_q <= fifo_cnt_q - 1'b1;
        default: fifo_cnt_q <= fifo_cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin : p_fifo_mem
    if (mem_rtrn_vld_i) begin
      fifo_q[fifo_wr_q] <= mem_rtrn_id_i;
    end
  end

  // a slot evicted now is still busy this cycle, so alloc never hits it
  always_ff @(posedge clk_i) begin : p_slot_vld
    if (reset_i) begin
      slot_vld_q <= '0;
    end else begin
      if (evict_o) begin
        slot_vld_q[rtrn_id] <= 1'b0;
      end
      if (alloc_i) begin
        slot_vld_q[alloc_id_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_slot_data
    if (alloc_i) begin
      slot_ptr_q[alloc_id_i] <= alloc_ptr_i;
      slot_be_q[alloc_id_i]  <= alloc_be_i;
    end
  end

endmodule

`default_nettype wire

/* hw/wbuf_issue.sv */
// issue stage of the write buffer
// picks a dirty entry round-robin and the lowest free transaction ID, drives
// the memory request port and reports the issued bytes to store and retire.
// a request that is not acked at once is held in registers until mem_ack_i

`timescale 1ns/1ps
`default_nettype none

`include "wbuf_params.svh"

module wbuf_issue import wbuf_pkg::*; (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // entry view from store
  input  entry_mask_t              dirty_i,
  input  be_t    [`WBUF_DEPTH-1:0] bdirty_i,
  input  wtag_t  [`WBUF_DEPTH-1:0] wtag_i,
  input  dword_t [`WBUF_DEPTH-1:0] data_i,
  // free slots from retire
  input  tx_mask_t                 tx_free_i,
  // memory request port
  output logic                     mem_req_o,
  output wtag_t                    mem_wtag_o,
  output dword_t                   mem_data_o,
  output be_t                      mem_be_o,
  output tx_id_t                   mem_id_o,
  input  logic                     mem_ack_i,
  // issued bytes back to store
  output logic                     sent_o,
  output entry_ptr_t               sent_ptr_o,
  output be_t                      sent_be_o,
  // slot allocation to retire
  output logic                     alloc_o,
  output tx_id_t                   alloc_id_o,
  output entry_ptr_t               alloc_ptr_o,
  output be_t                      alloc_be_o
);

  entry_ptr_t rr_q;
  entry_ptr_t sel_ptr;
  tx_id_t     free_id;
  logic       start;
  logic       wait_q;

  // held request while the memory stalls
  wtag_t  hold_wtag_q;
  dword_t hold_data_q;
  be_t    hold_be_q;
  tx_id_t hold_id_q;

  ////////////////////////////////////////////////////////////////////////////
  // entry and ID choice
  ////////////////////////////////////////////////////////////////////////////

  // first dirty entry at or after the round-robin pointer
  always_comb begin : p_rr
    entry_ptr_t cand;
    sel_ptr = rr_q;
    for (int i = `WBUF_DEPTH-1; i >= 0; i--) begin
      cand = rr_q + entry_ptr_t'(i);
      if (dirty_i[cand]) begin
        sel_ptr = cand;
      end
    end
  end

  // lowest free slot
  always_comb begin : p_id
    free_id = '0;
    for (int t = `WBUF_MAX_TX-1; t >= 0; t--) begin
      if (tx_free_i[t]) begin
        free_id = tx_id_t'(t);
      end
    end
  end

  // a new request needs an issuable entry and a slot
  assign start = ~wait_q & (|dirty_i) & (|tx_free_i);

  ////////////////////////////////////////////////////////////////////////////
  // memory request port
  ////////////////////////////////////////////////////////////////////////////

  // first cycle comes straight from the entry, later cycles from the hold regs,
  // so a store merging into the entry cannot disturb a stalled request
  assign mem_req_o  = wait_q | start;
  assign mem_wtag_o = wait_q ? hold_wtag_q : wtag_i[sel_ptr];
  assign mem_data_o = wait_q ? hold_data_q : data_i[sel_ptr];
  assign mem_be_o   = wait_q ? hold_be_q : bdirty_i[sel_ptr];
  assign mem_id_o   = wait_q ? hold_id_q : free_id;

  // bytes are marked in flight in the first request cycle, a rewrite after
  // that point is dirty again and goes out after the response
  assign sent_o     = start;
  assign sent_ptr_o = sel_ptr;
  assign sent_be_o  = bdirty_i[sel_ptr];

  // slot reserved at the same time, no response can come before the transfer
  assign alloc_o     = start;
  assign alloc_id_o  = free_id;
  assign alloc_ptr_o = sel_ptr;
  assign alloc_be_o  = bdirty_i[sel_ptr];

  always_ff @(posedge clk_i) begin : p_ctrl
    if (reset_i) begin
      rr_q   <= '0;
      wait_q <= 1'b0;
    end else begin
      // pointer moves past the chosen entry, locked while waiting
      if (start) begin
        rr_q <= sel_ptr + entry_ptr_t'(1);
      end
      wait_q <= mem_req_o & ~mem_ack_i;
    end
  end

  always_ff @(posedge clk_i) begin : p_hold
    if (start) begin
      hold_wtag_q <= wtag_i[sel_ptr];
      hold_data_q <= data_i[sel_ptr];
      hold_be_q   <= bdirty_i[sel_ptr];
      hold_id_q   <= free_id;
    end
  end

endmodule

`default_nettype wire

/* hw/wbuf_store.sv */
// store stage of the write buffer
// holds the entry array with per-byte valid/dirty/txblock state, grants core
// stores and merges them into a hit entry or the lowest free one.
// issue reads the issuable bytes from here, retire sends back evictions
//   v/d/t = 0/0/0 free, 1/1/0 dirty, 1/0/1 in flight, 1/1/1 rewritten in flight

`timescale 1ns/1ps
`default_nettype none

`include "wbuf_params.svh"

module wbuf_store import wbuf_pkg::*; (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // core store port
  input  logic                     st_req_i,
  input  logic [`WBUF_ADDR_W-1:0]  st_addr_i,
  input  dword_t                   st_data_i,
  input  be_t                      st_be_i,
  output logic                     st_gnt_o,
  // bytes handed to memory by issue
  input  logic                     sent_i,
  input  entry_ptr_t               sent_ptr_i,
  input  be_t                      sent_be_i,
  // returned transaction from retire
  input  logic                     evict_i,
  input  entry_ptr_t               evict_ptr_i,
  input  be_t                      evict_be_i,
  // entry view for issue
  output entry_mask_t              dirty_o,
  output be_t    [`WBUF_DEPTH-1:0] bdirty_o,
  output wtag_t  [`WBUF_DEPTH-1:0] wtag_o,
  output dword_t [`WBUF_DEPTH-1:0] data_o,
  output logic                     empty_o
);

  // entry array
  wtag_t  [`WBUF_DEPTH-1:0] wtag_q, wtag_d;
  dword_t [`WBUF_DEPTH-1:0] data_q, data_d;
  be_t    [`WBUF_DEPTH-1:0] valid_q, valid_d;
  be_t    [`WBUF_DEPTH-1:0] dirty_q, dirty_d;
  be_t    [`WBUF_DEPTH-1:0] txblock_q, txblock_d;

  entry_mask_t ent_vld;
  entry_mask_t hit_oh;
  entry_ptr_t  hit_ptr;
  entry_ptr_t  free_ptr;
  entry_ptr_t  wr_ptr;
  wtag_t       st_wtag;
  logic        st_hit;
  logic        full;
  logic        st_wr;

  ////////////////////////////////////////////////////////////////////////////
  // entry flags
  ////////////////////////////////////////////////////////////////////////////

  assign st_wtag = st_addr_i[`WBUF_ADDR_W-1:$clog2(`WBUF_BE_W)];

  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_flags
    assign ent_vld[k] = |valid_q[k];
    // tags are unique, an entry is only allocated on a miss
    assign hit_oh[k]  = ent_vld[k] & (wtag_q[k] == st_wtag);
    // nothing of an entry goes out while any of its bytes is in flight,
    // two writes to one dword could overtake each other in memory
    assign bdirty_o[k] = (|txblock_q[k]) ? '0 : (valid_q[k] & dirty_q[k]);
    assign dirty_o[k]  = |bdirty_o[k];
  end

  // hit index and lowest free entry, lowest index wins
  always_comb begin : p_search
    hit_ptr  = '0;
    free_ptr = '0;
    for (int k = `WBUF_DEPTH-1; k >= 0; k--) begin
      if (hit_oh[k]) begin
        hit_ptr = entry_ptr_t'(k);
      end
      if (!ent_vld[k]) begin
        free_ptr = entry_ptr_t'(k);
      end
    end
  end

  assign st_hit   = |hit_oh;
  assign full     = &ent_vld;
  assign wr_ptr   = st_hit ? hit_ptr : free_ptr;
  // grant in the request cycle if the dword coalesces or an entry is free
  assign st_gnt_o = st_hit | ~full;
  assign st_wr    = st_req_i & st_gnt_o;

  assign empty_o = ~(|ent_vld);
  assign wtag_o  = wtag_q;
  assign data_o  = data_q;

  ////////////////////////////////////////////////////////////////////////////
  // update: eviction, then sent bytes, then the new store
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_update
    wtag_d    = wtag_q;
    data_d    = data_q;
    valid_d   = valid_q;
    dirty_d   = dirty_q;
    txblock_d = txblock_q;

    // response back: unblock the bytes, drop the ones not rewritten meanwhile
    if (evict_i) begin
      txblock_d[evict_ptr_i] = txblock_d[evict_ptr_i] & ~evict_be_i;
      valid_d[evict_ptr_i]   = valid_d[evict_ptr_i] & ~(evict_be_i & ~dirty_q[evict_ptr_i]);
    end

    // bytes now owned by a transaction
    if (sent_i) begin
      dirty_d[sent_ptr_i]   = dirty_d[sent_ptr_i] & ~sent_be_i;
      txblock_d[sent_ptr_i] = txblock_d[sent_ptr_i] | sent_be_i;
    end

    // a store in the same cycle sets dirty again, so a sent byte goes out once more
    if (st_wr) begin
      wtag_d[wr_ptr] = st_wtag;
      for (int b = 0; b < `WBUF_BE_W; b++) begin
        if (st_be_i[b]) begin
          valid_d[wr_ptr][b]      = 1'b1;
          dirty_d[wr_ptr][b]      = 1'b1;
          data_d[wr_ptr][b*8 +: 8] = st_data_i[b*8 +: 8];
        end
      end
    end
  end

  // byte state
  always_ff @(posedge clk_i) begin : p_state
    if (reset_i) begin
      valid_q   <= '0;
      dirty_q   <= '0;
      txblock_q <= '0;
    end else begin
      valid_q   <= valid_d;
      dirty_q   <= dirty_d;
      txblock_q <= txblock_d;
    end
  end

  // tags and data, meaningless while the byte is invalid
  always_ff @(posedge clk_i) begin : p_payload
    wtag_q <= wtag_d;
    data_q <= data_d;
  end

endmodule

`default_nettype wire

/* hw/wbuf_pkg.sv */
// types shared by the write buffer stages
// every RTL module imports this package by wildcard in its header,
// the sizes behind the types come from the params header

`default_nettype none

`include "wbuf_params.svh"

package wbuf_pkg;

  // dword address, byte address without the offset inside the dword
  typedef logic [`WBUF_ADDR_W-$clog2(`WBUF_BE_W)-1:0] wtag_t;

  // payload of one entry and its byte mask
  typedef logic [`WBUF_DATA_W-1:0] dword_t;
  typedef logic [`WBUF_BE_W-1:0]   be_t;

  // index of an entry, index of a transaction slot
  typedef logic [$clog2(`WBUF_DEPTH)-1:0]  entry_ptr_t;
  typedef logic [$clog2(`WBUF_MAX_TX)-1:0] tx_id_t;

  // one bit per entry, one bit per slot
  typedef logic [`WBUF_DEPTH-1:0]  entry_mask_t;
  typedef logic [`WBUF_MAX_TX-1:0] tx_mask_t;

endpackage

`default_nettype wire

/* hw/wbuf_params.svh */
// sizes of the coalescing write buffer
// included by the type package and by every module that sizes arrays or loops
// with these values; the include guard keeps repeated inclusion harmless

`ifndef WBUF_PARAMS_SVH
`define WBUF_PARAMS_SVH

// number of dword entries in the buffer
// must be a power of two, the round-robin pointer wraps by truncation
`define WBUF_DEPTH  4

// transaction slots, one ID per slot, also a power of two
`define WBUF_MAX_TX 2

// byte address width on the core side
`define WBUF_ADDR_W 32

// one buffer entry holds a dword
`define WBUF_DATA_W 64
`define WBUF_BE_W   8

`endif
